/* verilog/block_sync_macros.svh */
`ifndef BLOCK_SYNC_MACROS_SVH
`define BLOCK_SYNC_MACROS_SVH

// coded block length and widths derived from it
`define BS_BLOCK_LEN 66
`define BS_INDEX_W 7
`define BS_CNT_W 16

// word addresses on the wishbone port
`define BS_ADDR_CTRL 3'd0
`define BS_ADDR_LOCK_CNT 3'd1
`define BS_ADDR_WINDOW 3'd2
`define BS_ADDR_INV_LIMIT 3'd3
`define BS_ADDR_STATUS 3'd4
`define BS_ADDR_SLIPS 3'd5

// configuration values loaded at reset
`define BS_DEF_LOCK_CNT 16'd64
`define BS_DEF_WINDOW 16'd1024
`define BS_DEF_INV_LIMIT 16'd16

`endif

/* verilog/block_sync_pkg.sv */
`include "block_sync_macros.svh"

package block_sync_pkg;

    // lock state of the block sync fsm
    typedef enum logic [1:0]
    {
        LOCK_RESET  = 2'd0,
        LOCK_SEARCH = 2'd1,
        LOCK_LOCKED = 2'd2
    } lock_state_t;

    // aligned 66-bit block, header on top as it arrives on the line
    typedef struct packed
    {
        logic [1:0]                   sync_header;
        logic [`BS_BLOCK_LEN-3:0]     payload;
    } coded_block_t;

    // configuration from the register block
    typedef struct packed
    {
        logic                         enable;
        logic [`BS_CNT_W-1:0]         lock_count;
        logic [`BS_CNT_W-1:0]         window_len;
        logic [`BS_CNT_W-1:0]         invalid_limit;
    } sync_cfg_t;

    // status back to the register block
    typedef struct packed
    {
        logic                         locked;
        logic                         slip_pulse;
        logic [`BS_INDEX_W-1:0]       index;
    } sync_status_t;

endpackage

/* verilog/block_sync_regs.sv */
`include "block_sync_macros.svh"

module block_sync_regs
    import block_sync_pkg::*;
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  logic [2:0]            i_wb_adr,
    input  logic [31:0]           i_wb_dat,
    output logic [31:0]           o_wb_dat,
    output logic                  o_wb_ack,
    output sync_cfg_t             o_cfg,
    input  sync_status_t          i_status
);

    sync_cfg_t             cfg_q;
    logic [`BS_CNT_W-1:0]  slip_count;
    logic                  request;
    logic                  wr_en;
    logic                  slips_clear;
    logic [31:0]           rd_data;

    // new request while no ack is pending, answered on the next edge
    assign request     = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign wr_en       = request && i_wb_we;
    assign slips_clear = wr_en && (i_wb_adr == `BS_ADDR_SLIPS);

    assign o_cfg = cfg_q;

    // read mux
    // status keeps locked in bit 0 and the index in bits 14:8
    always_comb
    begin
        rd_data = 32'd0;
        case (i_wb_adr)
            `BS_ADDR_CTRL:      rd_data[0] = cfg_q.enable;
            `BS_ADDR_LOCK_CNT:  rd_data[`BS_CNT_W-1:0] = cfg_q.lock_count;
            `BS_ADDR_WINDOW:    rd_data[`BS_CNT_W-1:0] = cfg_q.window_len;
            `BS_ADDR_INV_LIMIT: rd_data[`BS_CNT_W-1:0] = cfg_q.invalid_limit;
            `BS_ADDR_STATUS:
            begin
                rd_data[0] = i_status.locked;
                rd_data[8 +: `BS_INDEX_W] = i_status.index;
            end
            `BS_ADDR_SLIPS:     rd_data[`BS_CNT_W-1:0] = slip_count;
            // addresses 6 and 7 read zero
            default:            rd_data = 32'd0;
        endcase
    end

    // bus handshake, ack is a single cycle pulse
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_wb_ack <= 1'b0;
            o_wb_dat <= 32'd0;
        end
        else
        begin
            o_wb_ack <= request;
            if (request && !i_wb_we)
            begin
                o_wb_dat <= rd_data;
            end
        end
    end

    // configuration registers, only low bits are kept
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            cfg_q.enable        <= 1'b1;
            cfg_q.lock_count    <= `BS_DEF_LOCK_CNT;
            cfg_q.window_len    <= `BS_DEF_WINDOW;
            cfg_q.invalid_limit <= `BS_DEF_INV_LIMIT;
        end
        else if (wr_en)
        begin
            case (i_wb_adr)
                `BS_ADDR_CTRL:      cfg_q.enable <= i_wb_dat[0];
                `BS_ADDR_LOCK_CNT:  cfg_q.lock_count <= i_wb_dat[`BS_CNT_W-1:0];
                `BS_ADDR_WINDOW:    cfg_q.window_len <= i_wb_dat[`BS_CNT_W-1:0];
                `BS_ADDR_INV_LIMIT: cfg_q.invalid_limit <= i_wb_dat[`BS_CNT_W-1:0];
                // status is read only, slips handled below
                default:            cfg_q <= cfg_q;
            endcase
        end
    end

    // slip counter, saturates at all ones
    // a write to it wins over a slip on the same edge
    always_ff @(posedge i_clock)
    begin
        if (i_reset || slips_clear)
        begin
            slip_count <= '0;
        end
        else if (i_status.slip_pulse && (slip_count != '1))
        begin
            slip_count <= slip_count + 1'b1;
        end
    end

endmodule

/* verilog/block_aligner.sv */
`include "block_sync_macros.svh"

module block_aligner
    import block_sync_pkg::*;
(
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic [`BS_BLOCK_LEN-1:0]   i_data,
    input  logic                       i_valid,
    input  logic                       i_enable,
    input  logic [`BS_INDEX_W-1:0]     i_index,
    output logic                       o_sh_valid,
    output coded_block_t               o_block,
    output logic                       o_block_valid
);

    // two words side by side, previous one on top
    localparam int ext_len = 2 * `BS_BLOCK_LEN;

    logic [`BS_BLOCK_LEN-1:0]  data_prev;
    logic [ext_len-1:0]        data_ext;
    logic [`BS_BLOCK_LEN-1:0]  window;
    logic                      advance;

    // a word only counts when the stream is enabled
    assign advance = i_valid && i_enable;

    assign data_ext = {data_prev, i_data};

    // window starts i_index bits below the top of the pair
    // index 0 selects the previous word as is
    assign window = data_ext[(ext_len - 1 - i_index) -: `BS_BLOCK_LEN];

    // header is good when its two bits differ, 01 or 10
    assign o_sh_valid = window[`BS_BLOCK_LEN-1] ^ window[`BS_BLOCK_LEN-2];

    // keep the last accepted word for the next window
    always_ff @(posedge i_clock)
    begin
        if (advance)
        begin
            data_prev <= i_data;
        end
    end

    // registered output block, one cycle after the accepted word
    always_ff @(posedge i_clock)
    begin
        if (advance)
        begin
            o_block <= window;
        end
    end

    // valid flag follows the accepted word by one cycle
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_block_valid <= 1'b0;
        end
        else
        begin
            o_block_valid <= advance;
        end
    end

endmodule

/* verilog/block_lock_fsm.sv */
`include "block_sync_macros.svh"

module block_lock_fsm
    import block_sync_pkg::*;
(
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_valid,
    input  logic                       i_signal_ok,
    input  logic                       i_sh_valid,
    input  sync_cfg_t                  i_cfg,
    output logic [`BS_INDEX_W-1:0]     o_index,
    output sync_status_t               o_status,
    output logic                       o_locked
);

    // last legal offset before wrapping back to 0
    localparam logic [`BS_INDEX_W-1:0] last_index = `BS_INDEX_W'(`BS_BLOCK_LEN - 1);

    lock_state_t               state;
    logic [`BS_INDEX_W-1:0]    index;
    logic [`BS_CNT_W-1:0]      good_cnt;
    logic [`BS_CNT_W-1:0]      win_cnt;
    logic [`BS_CNT_W-1:0]      inv_cnt;
    logic                      slip_pulse;
    logic                      advance;
    logic [`BS_INDEX_W-1:0]    index_next;
    // one extra bit so a shrunk limit never wraps the compare
    logic [`BS_CNT_W:0]        good_next;
    logic [`BS_CNT_W:0]        win_next;
    logic [`BS_CNT_W:0]        inv_next;

    // headers are only looked at on enabled valid words
    assign advance = i_valid && i_cfg.enable;

    // slip moves one bit further, modulo the block length
    assign index_next = (index >= last_index) ? '0 : index + 1'b1;

    assign good_next = {1'b0, good_cnt} + 1'b1;
    assign win_next  = {1'b0, win_cnt} + 1'b1;
    assign inv_next  = {1'b0, inv_cnt} + {{`BS_CNT_W{1'b0}}, !i_sh_valid};

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state      <= LOCK_RESET;
            index      <= '0;
            good_cnt   <= '0;
            win_cnt    <= '0;
            inv_cnt    <= '0;
            slip_pulse <= 1'b0;
        end
        else if (!i_signal_ok)
        begin
            // loss of signal restarts the search, offset is kept
            state      <= LOCK_RESET;
            good_cnt   <= '0;
            win_cnt    <= '0;
            inv_cnt    <= '0;
            slip_pulse <= 1'b0;
        end
        else
        begin
            slip_pulse <= 1'b0;
            case (state)
                LOCK_RESET:
                begin
                    state    <= LOCK_SEARCH;
                    good_cnt <= '0;
                    win_cnt  <= '0;
                    inv_cnt  <= '0;
                end
                LOCK_SEARCH:
                begin
                    if (advance && !i_sh_valid)
                    begin
                        // bad header, try the next offset from scratch
                        index      <= index_next;
                        good_cnt   <= '0;
                        slip_pulse <= 1'b1;
                    end
                    else if (advance && (good_next >= {1'b0, i_cfg.lock_count}))
                    begin
                        // enough good headers in a row
                        state    <= LOCK_LOCKED;
                        good_cnt <= '0;
                        win_cnt  <= '0;
                        inv_cnt  <= '0;
                    end
                    else if (advance)
                    begin
                        good_cnt <= good_next[`BS_CNT_W-1:0];
                    end
                end
                LOCK_LOCKED:
                begin
                    if (advance && !i_sh_valid && (inv_next >= {1'b0, i_cfg.invalid_limit}))
                    begin
                        // too many bad headers in this window
                        state      <= LOCK_SEARCH;
                        index      <= index_next;
                        slip_pulse <= 1'b1;
                        good_cnt   <= '0;
                        win_cnt    <= '0;
                        inv_cnt    <= '0;
                    end
                    else if (advance && (win_next >= {1'b0, i_cfg.window_len}))
                    begin
                        // window done, start a fresh one
                        win_cnt <= '0;
                        inv_cnt <= '0;
                    end
                    else if (advance)
                    begin
                        win_cnt <= win_next[`BS_CNT_W-1:0];
                        inv_cnt <= inv_next[`BS_CNT_W-1:0];
                    end
                end
                default:
                begin
                    state <= LOCK_RESET;
                end
            endcase
        end
    end

    assign o_index  = index;
    assign o_locked = (state == LOCK_LOCKED);

    // status to the register block
    assign o_status.locked     = (state == LOCK_LOCKED);
    assign o_status.slip_pulse = slip_pulse;
    assign o_status.index      = index;

endmodule

/* verilog/block_sync_top.sv */
`include "block_sync_macros.svh"

module block_sync_top
    import block_sync_pkg::*;
(
    input  logic                       i_clock,
    input  logic                       i_reset,
    // word stream from the serial to parallel stage
    input  logic [`BS_BLOCK_LEN-1:0]   i_data,
    input  logic                       i_valid,
    input  logic                       i_signal_ok,
    // aligned blocks out
    output coded_block_t               o_block,
    output logic                       o_block_valid,
    output logic                       o_locked,
    // wishbone classic slave
    input  logic                       i_wb_cyc,
    input  logic                       i_wb_stb,
    input  logic                       i_wb_we,
    input  logic [2:0]                 i_wb_adr,
    input  logic [31:0]                i_wb_dat,
    output logic [31:0]                o_wb_dat,
    output logic                       o_wb_ack
);

    sync_cfg_t                 cfg;
    sync_status_t              status;
    logic                      sh_valid;
    logic [`BS_INDEX_W-1:0]    index;

    // configuration and status registers
    block_sync_regs u_regs
    (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .o_cfg      (cfg),
        .i_status   (status)
    );

    // window select and header test
    // enable gates the word stream here
    block_aligner u_aligner
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_data         (i_data),
        .i_valid        (i_valid),
        .i_enable       (cfg.enable),
        .i_index        (index),
        .o_sh_valid     (sh_valid),
        .o_block        (o_block),
        .o_block_valid  (o_block_valid)
    );

    // lock search and slip control
    block_lock_fsm u_fsm
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_signal_ok    (i_signal_ok),
        .i_sh_valid     (sh_valid),
        .i_cfg          (cfg),
        .o_index        (index),
        .o_status       (status),
        .o_locked       (o_locked)
    );

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen
(
    output logic o_clock,
    output logic o_reset
);

    // period 20, reset held for the first 3 rising edges
    initial
    begin
        o_clock = 1'b0;
        forever #10 o_clock = ~o_clock;
    end

    initial
    begin
        o_reset = 1'b1;
        repeat (3) @(posedge o_clock);
        o_reset <= 1'b0;
    end

endmodule

/* testbench/tb_block_sync_checks.sv */
module tb_block_sync_checks
    import block_sync_pkg::*;
(
    input  logic          i_clock,
    input  logic          i_reset,
    input  logic          i_valid,
    input  logic          i_check,
    input  logic          i_locked,
    input  coded_block_t  i_expected,
    input  coded_block_t  i_block,
    input  logic          i_block_valid,
    output logic          o_failed
);

    coded_block_t  exp_q;
    logic          check_q;
    logic          locked_q;

    // the stream is valid every cycle, so o_block always belongs to last cycle's word
    // locked_q is the lock state seen when that word was judged
    always @(posedge i_clock)
    begin
        if (i_reset)
        begin
            check_q  <= 1'b0;
            locked_q <= 1'b0;
        end
        else
        begin
            exp_q    <= i_expected;
            check_q  <= i_check && i_valid;
            locked_q <= i_locked;
        end
    end

    always @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_failed <= 1'b0;
        end
        else if (i_block_valid && locked_q && check_q)
        begin
            // header of an aligned block is 01 or 10
            assert (i_block.sync_header == 2'b01 || i_block.sync_header == 2'b10)
            else
            begin
                $display("mismatch at %0t: o_block.sync_header expected 01 or 10 got %b",
                    $time, i_block.sync_header);
                o_failed <= 1'b1;
            end
            // whole block against the model queue
            assert (i_block == exp_q)
            else
            begin
                $display("mismatch at %0t: o_block expected %h got %h",
                    $time, exp_q, i_block);
                o_failed <= 1'b1;
            end
        end
    end

endmodule

/* testbench/tb_block_sync.sv */
`include "block_sync_macros.svh"

module tb_block_sync
    import block_sync_pkg::*;
();

    // bit offset of the line stream, kept below 6 by the payload tail rule
    localparam int offset_k = 5;
    localparam int planned_words = 600;
    localparam int planned_wb = 30;
    localparam longint watchdog_time = 20 * (planned_words + 4 * planned_wb) * 20;
    // status word once locked at offset_k, index in bits 14:8 and lock flag in bit 0
    localparam logic [31:0] status_locked = 32'(offset_k << 8) | 32'd1;

    logic          clock;
    logic          reset;
    logic [65:0]   i_data;
    logic          i_valid;
    logic          i_signal_ok;
    coded_block_t  o_block;
    logic          o_block_valid;
    logic          o_locked;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    logic [2:0]    wb_adr;
    logic [31:0]   wb_dat;
    logic [31:0]   o_wb_dat;
    logic          o_wb_ack;
    logic          chk_failed;

    // stream model state
    logic          stream_run;
    logic          clean;
    int            corrupt_left;
    coded_block_t  prev_block;
    coded_block_t  expected;
    logic [1:0]    hdr_next;
    coded_block_t  sent_q[$];

    tb_clock_gen clock0
    (
        .o_clock (clock),
        .o_reset (reset)
    );

    block_sync_top dut0
    (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_data        (i_data),
        .i_valid       (i_valid),
        .i_signal_ok   (i_signal_ok),
        .o_block       (o_block),
        .o_block_valid (o_block_valid),
        .o_locked      (o_locked),
        .i_wb_cyc      (wb_cyc),
        .i_wb_stb      (wb_stb),
        .i_wb_we       (wb_we),
        .i_wb_adr      (wb_adr),
        .i_wb_dat      (wb_dat),
        .o_wb_dat      (o_wb_dat),
        .o_wb_ack      (o_wb_ack)
    );

    tb_block_sync_checks checks0
    (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_valid       (i_valid),
        .i_check       (clean),
        .i_locked      (o_locked),
        .i_expected    (expected),
        .i_block       (o_block),
        .i_block_valid (o_block_valid),
        .o_failed      (chk_failed)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped on the first error");
    endtask

    // new random block, the payload tail copies the first bit of the next header
    // so that no offset short of the true one shows a valid header
    function automatic coded_block_t make_block();
        coded_block_t blk;
        blk.sync_header = hdr_next;
        hdr_next = (($urandom() & 32'd1) != 32'd0) ? 2'b10 : 2'b01;
        blk.payload = {$urandom(), $urandom()};
        blk.payload[5:0] = {6{hdr_next[1]}};
        return blk;
    endfunction

    // serialize, delay by offset_k and cut, word n carries the tail of block n-1
    // block n-1 is first seen whole at index offset_k in word n
    task automatic drive_word();
        coded_block_t blk;
        logic [131:0] shifted;
        blk = make_block();
        if (corrupt_left > 0)
        begin
            // 01 becomes 00 and 10 becomes 11
            blk.sync_header[0] = ~blk.sync_header[0];
            corrupt_left <= corrupt_left - 1;
        end
        shifted = {prev_block, blk} >> offset_k;
        sent_q.push_back(blk);
        if (sent_q.size() > 1)
        begin
            expected <= sent_q.pop_front();
        end
        i_data     <= shifted[65:0];
        i_valid    <= 1'b1;
        prev_block <= blk;
    endtask

    always @(posedge clock)
    begin
        if (stream_run)
        begin
            drive_word();
        end
        else
        begin
            i_valid <= 1'b0;
        end
    end

    // one classic cycle, ack must come one cycle after stb and last one cycle
    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int cycles;
        @(posedge clock);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= we;
        wb_adr <= adr;
        wb_dat <= wdat;
        cycles = 0;
        do
        begin
            @(posedge clock);
            cycles++;
        end
        while (!o_wb_ack && cycles < 10);
        assert (cycles == 2) else fail_now("wishbone ack did not come one cycle after stb");
        rdat = o_wb_dat;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(posedge clock);
        assert (!o_wb_ack) else fail_now("wishbone ack stayed high for more than one cycle");
    endtask

    task automatic write_reg(input logic [2:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic read_expect(input logic [2:0] adr, input logic [31:0] exp, input string name);
        logic [31:0] rdat;
        wb_access(1'b0, adr, 32'd0, rdat);
        assert (rdat == exp)
        else
        begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, rdat);
            fail_now("register read back wrong");
        end
    endtask

    task automatic wait_locked(input logic level, input int max_cycles, input string what);
        int n;
        n = 0;
        while (o_locked !== level && n < max_cycles)
        begin
            @(posedge clock);
            n++;
        end
        assert (o_locked === level) else fail_now(what);
    endtask

    always @(posedge chk_failed)
    begin
        fail_now("output block check failed");
    end

    // watchdog sized from the planned words and bus cycles
    initial
    begin
        #(watchdog_time);
        fail_now("timeout, the run did not finish in time");
    end

    initial
    begin
        logic [31:0] rdat;
        int n;
        void'($urandom(32'hd197aeb7));
        i_data       = '0;
        i_valid      = 1'b0;
        i_signal_ok  = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat       = '0;
        stream_run   = 1'b0;
        clean        = 1'b1;
        corrupt_left = 0;
        prev_block   = '0;
        expected     = '0;
        hdr_next     = 2'b01;
        do @(posedge clock); while (reset);

        // register defaults and write back
        read_expect(`BS_ADDR_CTRL, 32'd1, "ctrl");
        read_expect(`BS_ADDR_LOCK_CNT, 32'(`BS_DEF_LOCK_CNT), "lock_count");
        read_expect(`BS_ADDR_WINDOW, 32'(`BS_DEF_WINDOW), "window_len");
        read_expect(`BS_ADDR_INV_LIMIT, 32'(`BS_DEF_INV_LIMIT), "invalid_limit");
        read_expect(`BS_ADDR_STATUS, 32'd0, "status");
        read_expect(`BS_ADDR_SLIPS, 32'd0, "slips");
        read_expect(3'd6, 32'd0, "unused address 6");
        write_reg(`BS_ADDR_LOCK_CNT, 32'd8);
        write_reg(`BS_ADDR_WINDOW, 32'd64);
        write_reg(`BS_ADDR_INV_LIMIT, 32'd4);
        read_expect(`BS_ADDR_LOCK_CNT, 32'd8, "lock_count");
        read_expect(`BS_ADDR_WINDOW, 32'd64, "window_len");
        read_expect(`BS_ADDR_INV_LIMIT, 32'd4, "invalid_limit");

        // first word primes the previous word while the fsm is held in reset
        @(posedge clock);
        stream_run <= 1'b1;
        @(posedge clock);
        i_signal_ok <= 1'b1;
        wait_locked(1'b1, 200, "lock was not reached on a clean stream");
        read_expect(`BS_ADDR_STATUS, status_locked, "status");
        read_expect(`BS_ADDR_SLIPS, 32'(offset_k), "slips");
        repeat (100) @(posedge clock);

        // loss of signal for one word, lock returns on the same offset
        @(posedge clock);
        i_signal_ok <= 1'b0;
        @(posedge clock);
        i_signal_ok <= 1'b1;
        wait_locked(1'b0, 4, "lock stayed up after loss of signal");
        wait_locked(1'b1, 40, "lock did not return after loss of signal");
        read_expect(`BS_ADDR_STATUS, status_locked, "status");
        read_expect(`BS_ADDR_SLIPS, 32'(offset_k), "slips");

        // stream disabled, nothing comes out and status holds
        // bad headers sent meanwhile must not reach the fsm
        clean <= 1'b0;
        write_reg(`BS_ADDR_CTRL, 32'd0);
        read_expect(`BS_ADDR_STATUS, status_locked, "status");
        corrupt_left <= 8;
        for (n = 0; n < 20; n++)
        begin
            @(posedge clock);
            assert (!o_block_valid) else fail_now("o_block_valid high while disabled");
        end
        read_expect(`BS_ADDR_STATUS, status_locked, "status");
        write_reg(`BS_ADDR_CTRL, 32'd1);
        n = 0;
        while (!o_block_valid && n < 5)
        begin
            @(posedge clock);
            n++;
        end
        assert (o_block_valid) else fail_now("stream did not resume after enable");
        // first window after resume mixes a stale word
        repeat (3) @(posedge clock);
        clean <= 1'b1;
        repeat (80) @(posedge clock);

        // a few bad headers in one window keep the lock
        clean <= 1'b0;
        corrupt_left <= 3;
        for (n = 0; n < 80; n++)
        begin
            @(posedge clock);
            assert (o_locked) else fail_now("lock dropped below the invalid limit");
        end

        // a run of bad headers covers the limit inside one window
        corrupt_left <= 8;
        wait_locked(1'b0, 30, "lock stayed up past the invalid limit");
        wb_access(1'b0, `BS_ADDR_STATUS, 32'd0, rdat);
        assert (rdat[14:8] != 7'(offset_k)) else fail_now("index did not change after unlock");
        wb_access(1'b0, `BS_ADDR_SLIPS, 32'd0, rdat);
        assert (rdat > 32'(offset_k)) else fail_now("slip counter did not grow after unlock");

        if (chk_failed)
        begin
            fail_now("output block check failed");
        end
        else
        begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* build.f */
+incdir+verilog
verilog/block_sync_pkg.sv
verilog/block_sync_regs.sv
verilog/block_aligner.sv
verilog/block_lock_fsm.sv
verilog/block_sync_top.sv
testbench/tb_clock_gen.sv
testbench/tb_block_sync_checks.sv
testbench/tb_block_sync.sv

/* run.sh */
#!/usr/bin/env bash
# builds the block sync testbench with verilator and runs it
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_block_sync -o sim_block_sync
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_block_sync
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
